// ==== tb.f ====
verilog/lsu_pkg.sv
verilog/excp_pkg.sv
verilog/exe_stage.sv
verilog/data_sram.sv
verilog/mem_stage.sv
verilog/wb_stage.sv
verilog/lsu_pipe_top.sv
testbench/tb_lsu_pipe.sv

// ==== Bender.yml ====
package:
  name: lsu_pipe

sources:
  - files:
      - verilog/lsu_pkg.sv
      - verilog/excp_pkg.sv
      - verilog/exe_stage.sv
      - verilog/data_sram.sv
      - verilog/mem_stage.sv
      - verilog/wb_stage.sv
      - verilog/lsu_pipe_top.sv
  - target: test
    files:
      - testbench/tb_lsu_pipe.sv

// ==== testbench/tb_lsu_pipe.sv ====
`timescale 1ns/1ps

module tb_lsu_pipe;
    import lsu_pkg::*;
    import excp_pkg::*;

    localparam int SRAM_LATENCY = 2;
    localparam int SRAM_DEPTH   = 256;
    localparam int MEM_AW       = $clog2(SRAM_DEPTH);
    localparam int N_RANDOM     = 300;

    typedef enum logic [1:0] {ev_retire, ev_excp, ev_ertn} ev_kind_e;

    typedef struct packed {
        ev_kind_e          kind;
        logic [DATA_W-1:0] pc;
        logic              we;
        logic [REG_AW-1:0] dest;
        logic [DATA_W-1:0] data;
        ecode_e            ecode;
        logic [DATA_W-1:0] badv;
    } event_t;

    typedef struct packed {
        op_e               op;
        logic [REG_AW-1:0] rj, rk, rd;
        logic [DATA_W-1:0] imm, pc;
        logic [3:0]        gap;
    } stim_t;

    logic              clk = 1'b0;
    logic              reset;
    logic              in_valid;
    op_e               in_op;
    logic [REG_AW-1:0] in_rj, in_rk, in_rd;
    logic [DATA_W-1:0] in_imm, in_pc;
    logic              in_allowin;
    logic              retire_valid, retire_we, excp_valid, ertn_valid;
    logic [DATA_W-1:0] retire_pc, retire_data, excp_badv, excp_pc;
    logic [REG_AW-1:0] retire_dest;
    ecode_e            excp_ecode;

    stim_t             stim_q[$];
    event_t            exp_q[$];
    event_t            head;
    stim_t             acc;
    logic              head_valid = 1'b0;
    logic              squash = 1'b0;
    logic              seen_accept = 1'b0;
    logic [DATA_W-1:0] regs [32];
    logic [DATA_W-1:0] model_mem [SRAM_DEPTH];
    int                errors = 0;
    int                n_accepted = 0, n_squashed = 0, n_retired = 0, n_excp = 0, n_ertn = 0;
    int                cycles = 0;
    int                cycle_limit = 1000;

    lsu_pipe_top #(
        .SRAM_LATENCY(SRAM_LATENCY),
        .SRAM_DEPTH  (SRAM_DEPTH)
    ) i_dut (.*);

    always #10 clk = ~clk;

    // ******************************
    // reference model
    // ******************************
    function automatic logic [DATA_W-1:0] load_value(op_e op, logic [DATA_W-1:0] word,
                                                     logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (op)
            op_ld_b:  return {{24{b[7]}}, b};
            op_ld_bu: return {24'h0, b};
            op_ld_h:  return {{16{h[15]}}, h};
            op_ld_hu: return {16'h0, h};
            default:  return word;
        endcase
    endfunction

    task automatic model_item(input stim_t it);
        logic [DATA_W-1:0] addr;
        logic [MEM_AW-1:0] widx;
        logic              bad;
        event_t            ev;
        addr    = regs[it.rj] + it.imm;
        widx    = addr[MEM_AW+1:2];
        ev      = '0;
        ev.kind = ev_retire;
        ev.pc   = it.pc;
        ev.dest = it.rd;
        case (it.op)
            op_ld_h, op_ld_hu: bad = addr[0];
            op_ld_w, op_st_w:  bad = addr[1:0] != 2'b00;
            default:           bad = 1'b0;
        endcase
        if (it.op == op_syscall) begin
            ev.kind  = ev_excp;
            ev.ecode = ecode_sys;
        end else if (it.op == op_ertn) begin
            ev.kind = ev_ertn;
        end else if (bad) begin
            ev.kind  = ev_excp;
            ev.ecode = ecode_ale;
            ev.badv  = addr;
        end else if (it.op == op_st_w) begin
            model_mem[widx] = regs[it.rk];
        end else begin
            ev.data = (it.op == op_add) ? addr : load_value(it.op, model_mem[widx], addr[1:0]);
            ev.we   = it.rd != '0;
        end
        if (ev.kind != ev_retire) squash = 1'b1;  // younger items die until the flush.
        if (ev.we) regs[it.rd] = ev.data;
        exp_q.push_back(ev);
    endtask

    // pops observed events, then runs the model on an accepted item.
    always @(posedge clk) begin
        if (!reset && (retire_valid || excp_valid || ertn_valid)) begin
            if (exp_q.size() != 0) void'(exp_q.pop_front());
            if (excp_valid || ertn_valid) squash = 1'b0;
            n_retired += retire_valid;
            n_excp    += excp_valid;
            n_ertn    += ertn_valid;
        end
        if (!reset && in_valid && in_allowin) begin
            acc         = '{op: in_op, rj: in_rj, rk: in_rk, rd: in_rd,
                            imm: in_imm, pc: in_pc, gap: '0};
            seen_accept = 1'b1;
            n_accepted++;
            if (squash) begin
                n_squashed++;
            end else begin
                model_item(acc);
            end
        end
        head_valid = exp_q.size() != 0;
        if (head_valid) head = exp_q[0];
    end

    // ******************************
    // checks
    // ******************************
    a_quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
        !seen_accept |-> !(retire_valid || excp_valid || ertn_valid))
        else begin
            errors++;
            $display("[ERROR] %0t valid output raised before any item was accepted", $time);
        end

    a_expected_event: assert property (@(posedge clk) disable iff (reset)
        (retire_valid || excp_valid || ertn_valid) |-> head_valid)
        else begin
            errors++;
            $display("an extra event came out of the pipeline at %0t with none expected", $time);
        end

    a_retire_match: assert property (@(posedge clk) disable iff (reset)
        retire_valid && head_valid |-> head.kind == ev_retire && retire_pc == head.pc &&
            retire_we == head.we &&
            (!head.we || (retire_dest == head.dest && retire_data == head.data)))
        else begin
            errors++;
            $display("[ERROR] %0t retire pc %h we %b rd %0d data %h, expected kind %0d pc %h",
                     $time, $sampled(retire_pc), $sampled(retire_we), $sampled(retire_dest),
                     $sampled(retire_data), $sampled(head.kind), $sampled(head.pc));
            $display("        expected we %b rd %0d data %h", $sampled(head.we),
                     $sampled(head.dest), $sampled(head.data));
        end

    a_excp_match: assert property (@(posedge clk) disable iff (reset)
        excp_valid && head_valid |-> head.kind == ev_excp && excp_pc == head.pc &&
            excp_ecode == head.ecode && (head.ecode != ecode_ale || excp_badv == head.badv))
        else begin
            errors++;
            $display("[ERROR] %0t exception pc %h ecode %h badv %h, expected kind %0d pc %h",
                     $time, $sampled(excp_pc), $sampled(excp_ecode), $sampled(excp_badv),
                     $sampled(head.kind), $sampled(head.pc));
        end

    a_ertn_match: assert property (@(posedge clk) disable iff (reset)
        ertn_valid && head_valid |-> head.kind == ev_ertn)
        else begin
            errors++;
            $display("[ERROR] %0t ertn seen, expected kind %0d pc %h",
                     $time, $sampled(head.kind), $sampled(head.pc));
        end

    // ******************************
    // stimulus
    // ******************************
    task automatic add_item(input op_e op, input int rj, input int rk, input int rd,
                            input logic [DATA_W-1:0] imm, input int gap);
        stim_t it;
        it = '{op: op, rj: rj, rk: rk, rd: rd, imm: imm,
               pc: 32'h1c00_0000 + 4 * stim_q.size(), gap: gap};
        stim_q.push_back(it);
    endtask

    task automatic build_directed();
        for (int r = 1; r < 32; r++) begin
            add_item(op_add, 0, 0, r, (r <= 3) ? 32'h100 * r : $urandom, $urandom_range(0, 2));
        end
        for (int off = 0; off < 4; off++) begin
            add_item(op_ld_b, 0, 0, 10, 32'h40 + off, 1);
            add_item(op_ld_bu, 0, 0, 11, 32'h40 + off, 0);
        end
        for (int off = 0; off < 4; off += 2) begin
            add_item(op_ld_h, 0, 0, 12, 32'h40 + off, 0);
            add_item(op_ld_hu, 0, 0, 13, 32'h40 + off, 0);
        end
        add_item(op_ld_w, 0, 0, 14, 32'h40, 0);
        add_item(op_st_w, 0, 20, 0, 32'h40, 0);
        add_item(op_ld_w, 0, 0, 15, 32'h40, 0);
        add_item(op_ld_b, 0, 0, 16, 32'h43, 0);
        // dependency chain sent back to back.
        add_item(op_add, 0, 0, 5, 32'h80, 2);
        add_item(op_ld_w, 5, 0, 6, 32'h0, 0);
        add_item(op_add, 6, 0, 7, 32'h1, 0);    // load-use stall.
        add_item(op_st_w, 5, 7, 0, 32'h4, 0);
        add_item(op_ld_w, 5, 0, 8, 32'h4, 0);
        add_item(op_add, 8, 0, 9, 32'h10, 1);
        add_item(op_ld_hu, 5, 0, 9, 32'h6, 0);
        // misaligned accesses with younger items behind them.
        add_item(op_ld_h, 0, 0, 17, 32'h81, 2);
        add_item(op_add, 0, 0, 18, 32'h55, 0);
        add_item(op_st_w, 0, 18, 0, 32'h80, 0);
        add_item(op_ld_w, 0, 0, 18, 32'h82, 3);
        add_item(op_st_w, 0, 9, 0, 32'h87, 0);
        add_item(op_add, 18, 0, 19, 32'h0, 4);
        add_item(op_st_w, 0, 9, 0, 32'h87, 2);
        add_item(op_ld_w, 0, 0, 24, 32'h80, 0);
        // syscall and ertn.
        add_item(op_syscall, 0, 0, 0, 32'h0, 2);
        add_item(op_add, 0, 0, 21, 32'h77, 0);
        add_item(op_ld_w, 0, 0, 22, 32'h40, 0);
        add_item(op_ertn, 0, 0, 0, 32'h0, 3);
        add_item(op_add, 0, 0, 21, 32'h99, 0);
        add_item(op_add, 21, 0, 23, 32'h0, 4);
    endtask

    task automatic build_random();
        op_e               loads [5] = '{op_ld_b, op_ld_h, op_ld_w, op_ld_bu, op_ld_hu};
        op_e               op;
        int                pick, rj, rd;
        logic [DATA_W-1:0] imm;
        for (int n = 0; n < N_RANDOM; n++) begin
            pick = $urandom_range(0, 99);
            if (pick < 30)      op = op_add;
            else if (pick < 80) op = loads[$urandom_range(0, 4)];
            else if (pick < 94) op = op_st_w;
            else if (pick < 97) op = op_syscall;
            else                op = op_ertn;
            rj  = (op == op_add) ? $urandom_range(0, 31) : $urandom_range(0, 3);
            imm = (op == op_add) ? $urandom : {$urandom_range(0, 63), 2'b00};
            if (op != op_add && $urandom_range(0, 4) == 0) imm += $urandom_range(1, 3);
            rd  = ($urandom_range(0, 19) == 0) ? 0 : $urandom_range(4, 31);  // r1-r3 hold bases.
            add_item(op, rj, $urandom_range(0, 31), rd, imm,
                     ($urandom_range(0, 9) < 6) ? 0 : $urandom_range(1, 3));
        end
    endtask

    task automatic send_item(input stim_t it);
        repeat (it.gap) @(posedge clk);
        in_valid <= 1'b1;
        in_op    <= it.op;
        in_rj    <= it.rj;
        in_rk    <= it.rk;
        in_rd    <= it.rd;
        in_imm   <= it.imm;
        in_pc    <= it.pc;
        @(posedge clk);
        while (!in_allowin) @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic print_summary();
        $display("%0d accepted, %0d squashed, %0d retired, %0d excp, %0d ertn, %0d errors",
                 n_accepted, n_squashed, n_retired, n_excp, n_ertn, errors);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d expected events never arrived",
                     cycles, exp_q.size());
            print_summary();
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        logic [DATA_W-1:0] w;
        void'($urandom(41084));
        reset    = 1'b1;
        in_valid = 1'b0;
        in_op    = op_add;
        in_rj    = '0;
        in_rk    = '0;
        in_rd    = '0;
        in_imm   = '0;
        in_pc    = '0;
        for (int r = 0; r < 32; r++) regs[r] = '0;
        for (int i = 0; i < SRAM_DEPTH; i++) begin
            w                    = $urandom;
            i_dut.i_sram.mem[i]  = w;
            model_mem[i]         = w;
        end
        build_directed();
        build_random();
        cycle_limit = 40 * stim_q.size() + 200;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        repeat (5) @(posedge clk);  // outputs must stay quiet here.
        foreach (stim_q[i]) send_item(stim_q[i]);
        while (exp_q.size() != 0) @(posedge clk);
        repeat (20) @(posedge clk);
        print_summary();
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== verilog/lsu_pipe_top.sv ====
`timescale 1ns/1ps

module lsu_pipe_top #(
    parameter int SRAM_LATENCY = 2,
    parameter int SRAM_DEPTH   = 256
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        in_valid,
    input  lsu_pkg::op_e                in_op,
    input  logic [lsu_pkg::REG_AW-1:0]  in_rj,
    input  logic [lsu_pkg::REG_AW-1:0]  in_rk,
    input  logic [lsu_pkg::REG_AW-1:0]  in_rd,
    input  logic [lsu_pkg::DATA_W-1:0]  in_imm,
    input  logic [lsu_pkg::DATA_W-1:0]  in_pc,
    output logic                        in_allowin,
    output logic                        retire_valid,
    output logic [lsu_pkg::DATA_W-1:0]  retire_pc,
    output logic                        retire_we,
    output logic [lsu_pkg::REG_AW-1:0]  retire_dest,
    output logic [lsu_pkg::DATA_W-1:0]  retire_data,
    output logic                        excp_valid,
    output excp_pkg::ecode_e            excp_ecode,
    output logic [excp_pkg::BADV_W-1:0] excp_badv,
    output logic [lsu_pkg::DATA_W-1:0]  excp_pc,
    output logic                        ertn_valid
);
    import lsu_pkg::*;
    import excp_pkg::*;

    localparam int AW = $clog2(SRAM_DEPTH);

    logic              es_to_ms_valid, ms_allowin, ms_to_ws_valid, ws_allowin, flush;
    op_e               es_op;
    logic [REG_AW-1:0] es_dest, ms_dest, ms_fwd_dest, ws_fwd_dest, rf_raddr1, rf_raddr2;
    logic              es_gr_we, es_mem_req, es_ertn, ms_gr_we, ms_ertn;
    logic [DATA_W-1:0] es_result, es_vaddr, es_pc, ms_final_result, ms_pc, ms_vaddr;
    ecode_e            es_ecode, ms_ecode;
    logic              ms_fwd_valid, ms_fwd_blk, ms_to_es_ex, ws_fwd_valid;
    logic [DATA_W-1:0] ms_fwd_data, ws_fwd_data, rf_rdata1, rf_rdata2;
    logic              sram_req, sram_wr, sram_data_ok;
    logic [AW-1:0]     sram_addr;
    logic [DATA_W-1:0] sram_wdata, sram_rdata;

    // stage ports share their names with the wires above.
    exe_stage #(.SRAM_DEPTH(SRAM_DEPTH)) i_exe (.*);

    data_sram #(
        .SRAM_LATENCY(SRAM_LATENCY),
        .SRAM_DEPTH  (SRAM_DEPTH)
    ) i_sram (
        .clk    (clk),
        .reset  (reset),
        .req    (sram_req),
        .wr     (sram_wr),
        .addr   (sram_addr),
        .wdata  (sram_wdata),
        .rdata  (sram_rdata),
        .data_ok(sram_data_ok)
    );

    mem_stage i_mem (.*);

    wb_stage i_wb (.*);

endmodule

// ==== verilog/wb_stage.sv ====
`timescale 1ns/1ps

module wb_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       ms_to_ws_valid,
    input  logic                       ms_gr_we,
    input  logic [lsu_pkg::REG_AW-1:0] ms_dest,
    input  logic [lsu_pkg::DATA_W-1:0] ms_final_result,
    input  excp_pkg::ecode_e           ms_ecode,
    input  logic                       ms_ertn,
    input  logic [lsu_pkg::DATA_W-1:0] ms_pc,
    input  logic [lsu_pkg::DATA_W-1:0] ms_vaddr,
    output logic                       ws_allowin,
    input  logic [lsu_pkg::REG_AW-1:0] rf_raddr1,
    input  logic [lsu_pkg::REG_AW-1:0] rf_raddr2,
    output logic [lsu_pkg::DATA_W-1:0] rf_rdata1,
    output logic [lsu_pkg::DATA_W-1:0] rf_rdata2,
    output logic                       ws_fwd_valid,
    output logic [lsu_pkg::REG_AW-1:0] ws_fwd_dest,
    output logic [lsu_pkg::DATA_W-1:0] ws_fwd_data,
    output logic                       flush,
    output logic                       retire_valid,
    output logic [lsu_pkg::DATA_W-1:0] retire_pc,
    output logic                       retire_we,
    output logic [lsu_pkg::REG_AW-1:0] retire_dest,
    output logic [lsu_pkg::DATA_W-1:0] retire_data,
    output logic                       excp_valid,
    output excp_pkg::ecode_e           excp_ecode,
    output logic [excp_pkg::BADV_W-1:0] excp_badv,
    output logic [lsu_pkg::DATA_W-1:0] excp_pc,
    output logic                       ertn_valid
);
    import lsu_pkg::*;
    import excp_pkg::*;

    logic              ws_valid;
    logic              gr_we_r, ertn_r, ws_ex, rf_we;
    logic [REG_AW-1:0] dest_r;
    logic [DATA_W-1:0] result_r, pc_r, vaddr_r;
    ecode_e            ecode_r;
    logic [DATA_W-1:0] rf [2**REG_AW];

    assign ws_allowin = 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else begin
            ws_valid <= ms_to_ws_valid;
        end

        if (ms_to_ws_valid) begin
            gr_we_r  <= ms_gr_we;
            dest_r   <= ms_dest;
            result_r <= ms_final_result;
            ecode_r  <= ms_ecode;
            ertn_r   <= ms_ertn;
            pc_r     <= ms_pc;
            vaddr_r  <= ms_vaddr;
        end
    end

    // ******************************
    // register file
    // ******************************
    assign rf_we = retire_valid && gr_we_r;

    always_ff @(posedge clk) begin
        if (rf_we && dest_r != '0) begin
            rf[dest_r] <= result_r;
        end
    end

    assign rf_rdata1 = (rf_raddr1 == '0) ? '0 : rf[rf_raddr1];  // r0 reads zero.
    assign rf_rdata2 = (rf_raddr2 == '0) ? '0 : rf[rf_raddr2];

    assign ws_fwd_valid = rf_we;
    assign ws_fwd_dest  = dest_r;
    assign ws_fwd_data  = result_r;

    // retire and event reporting.
    assign ws_ex        = ecode_r != ecode_none;
    assign retire_valid = ws_valid && !ws_ex && !ertn_r;
    assign retire_pc    = pc_r;
    assign retire_we    = gr_we_r;
    assign retire_dest  = dest_r;
    assign retire_data  = result_r;
    assign excp_valid   = ws_valid && ws_ex;
    assign excp_ecode   = ecode_r;
    assign excp_badv    = vaddr_r;
    assign excp_pc      = pc_r;
    assign ertn_valid   = ws_valid && ertn_r;
    assign flush        = excp_valid || ertn_valid;

    a_one_event: assert property (
        @(posedge clk) disable iff (reset) !(excp_valid && ertn_valid)
    ) else $error("exception and ertn reported together.");

endmodule

// ==== verilog/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       es_to_ms_valid,
    input  lsu_pkg::op_e               es_op,
    input  logic [lsu_pkg::REG_AW-1:0] es_dest,
    input  logic                       es_gr_we,
    input  logic [lsu_pkg::DATA_W-1:0] es_result,
    input  logic [lsu_pkg::DATA_W-1:0] es_vaddr,
    input  logic                       es_mem_req,
    input  excp_pkg::ecode_e           es_ecode,
    input  logic                       es_ertn,
    input  logic [lsu_pkg::DATA_W-1:0] es_pc,
    output logic                       ms_allowin,
    input  logic                       ws_allowin,
    input  logic [lsu_pkg::DATA_W-1:0] sram_rdata,
    input  logic                       sram_data_ok,
    input  logic                       flush,
    output logic                       ms_to_ws_valid,
    output logic                       ms_gr_we,
    output logic [lsu_pkg::REG_AW-1:0] ms_dest,
    output logic [lsu_pkg::DATA_W-1:0] ms_final_result,
    output excp_pkg::ecode_e           ms_ecode,
    output logic                       ms_ertn,
    output logic [lsu_pkg::DATA_W-1:0] ms_pc,
    output logic [lsu_pkg::DATA_W-1:0] ms_vaddr,
    output logic                       ms_fwd_valid,
    output logic [lsu_pkg::REG_AW-1:0] ms_fwd_dest,
    output logic [lsu_pkg::DATA_W-1:0] ms_fwd_data,
    output logic                       ms_fwd_blk,
    output logic                       ms_to_es_ex
);
    import lsu_pkg::*;
    import excp_pkg::*;

    logic              ms_valid;
    logic              ms_ready_go;
    op_e               op_r;
    logic [REG_AW-1:0] dest_r;
    logic              gr_we_r, mem_req_r, ertn_r;
    logic [DATA_W-1:0] result_r, vaddr_r, pc_r;
    ecode_e            ecode_r;
    logic [DATA_W-1:0] shifted;
    logic [DATA_W-1:0] mem_result;

    // a memory item waits for its data_ok, anything else is ready at once.
    assign ms_ready_go    = !mem_req_r || sram_data_ok;
    assign ms_allowin     = !ms_valid || ms_ready_go && ws_allowin;
    assign ms_to_ws_valid = ms_valid && ms_ready_go && !flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (flush) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end

        if (es_to_ms_valid && ms_allowin) begin
            op_r      <= es_op;
            dest_r    <= es_dest;
            gr_we_r   <= es_gr_we;
            result_r  <= es_result;
            vaddr_r   <= es_vaddr;
            mem_req_r <= es_mem_req;
            ecode_r   <= es_ecode;
            ertn_r    <= es_ertn;
            pc_r      <= es_pc;
        end
    end

    // ******************************
    // load extraction
    // ******************************
    always_comb begin
        shifted = sram_rdata >> {vaddr_r[1:0], 3'b000};
        case (op_r)
            op_ld_b:  mem_result = {{24{shifted[7]}}, shifted[7:0]};
            op_ld_bu: mem_result = {24'b0, shifted[7:0]};
            op_ld_h:  mem_result = {{16{shifted[15]}}, shifted[15:0]};
            op_ld_hu: mem_result = {16'b0, shifted[15:0]};
            default:  mem_result = sram_rdata;
        endcase
    end

    assign ms_final_result = is_load(op_r) ? mem_result : result_r;

    assign ms_gr_we = gr_we_r;
    assign ms_dest  = dest_r;
    assign ms_ecode = ecode_r;
    assign ms_ertn  = ertn_r;
    assign ms_pc    = pc_r;
    assign ms_vaddr = vaddr_r;

    // forward path.
    assign ms_fwd_valid = ms_to_ws_valid && gr_we_r;
    assign ms_fwd_dest  = dest_r;
    assign ms_fwd_data  = ms_final_result;
    assign ms_fwd_blk   = ms_valid && mem_req_r && is_load(op_r) && gr_we_r && !sram_data_ok;
    assign ms_to_es_ex  = ms_valid && (ecode_r != ecode_none || ertn_r);

    a_ok_has_owner: assert property (
        @(posedge clk) disable iff (reset) sram_data_ok |-> ms_valid && mem_req_r
    ) else $error("data_ok with no memory item in ms.");

endmodule

// ==== verilog/data_sram.sv ====
`timescale 1ns/1ps

module data_sram #(
    parameter int SRAM_LATENCY = 2,
    parameter int SRAM_DEPTH   = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          req,
    input  logic                          wr,
    input  logic [$clog2(SRAM_DEPTH)-1:0] addr,
    input  logic [lsu_pkg::DATA_W-1:0]    wdata,
    output logic [lsu_pkg::DATA_W-1:0]    rdata,
    output logic                          data_ok
);
    import lsu_pkg::*;

    logic [DATA_W-1:0]       mem [SRAM_DEPTH];
    logic [SRAM_LATENCY-1:0] ok_pipe;
    logic [DATA_W-1:0]       data_pipe [SRAM_LATENCY];

    // storage, write lands when the request is taken.
    always_ff @(posedge clk) begin
        if (req && wr) begin
            mem[addr] <= wdata;
        end
    end

    // ******************************
    // response delay line
    // ******************************
    always_ff @(posedge clk) begin
        if (reset) begin
            ok_pipe <= '0;
        end else begin
            ok_pipe[0] <= req;
            for (int i = 1; i < SRAM_LATENCY; i++) begin
                ok_pipe[i] <= ok_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        data_pipe[0] <= mem[addr];  // old word for a store.
        for (int i = 1; i < SRAM_LATENCY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign data_ok = ok_pipe[SRAM_LATENCY-1];
    assign rdata   = data_pipe[SRAM_LATENCY-1];

    a_ok_has_req: assert property (
        @(posedge clk) disable iff (reset) data_ok |-> $past(req, SRAM_LATENCY)
    ) else $error("data_ok without a request %0d cycles earlier.", SRAM_LATENCY);

endmodule

// ==== verilog/exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage #(
    parameter int SRAM_DEPTH = 256
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              in_valid,
    input  lsu_pkg::op_e                      in_op,
    input  logic [lsu_pkg::REG_AW-1:0]        in_rj,
    input  logic [lsu_pkg::REG_AW-1:0]        in_rk,
    input  logic [lsu_pkg::REG_AW-1:0]        in_rd,
    input  logic [lsu_pkg::DATA_W-1:0]        in_imm,
    input  logic [lsu_pkg::DATA_W-1:0]        in_pc,
    output logic                              in_allowin,
    output logic [lsu_pkg::REG_AW-1:0]        rf_raddr1,
    output logic [lsu_pkg::REG_AW-1:0]        rf_raddr2,
    input  logic [lsu_pkg::DATA_W-1:0]        rf_rdata1,
    input  logic [lsu_pkg::DATA_W-1:0]        rf_rdata2,
    input  logic                              ms_fwd_valid,
    input  logic [lsu_pkg::REG_AW-1:0]        ms_fwd_dest,
    input  logic [lsu_pkg::DATA_W-1:0]        ms_fwd_data,
    input  logic                              ms_fwd_blk,
    input  logic                              ms_to_es_ex,
    input  logic                              ws_fwd_valid,
    input  logic [lsu_pkg::REG_AW-1:0]        ws_fwd_dest,
    input  logic [lsu_pkg::DATA_W-1:0]        ws_fwd_data,
    input  logic                              flush,
    input  logic                              ms_allowin,
    output logic                              es_to_ms_valid,
    output lsu_pkg::op_e                      es_op,
    output logic [lsu_pkg::REG_AW-1:0]        es_dest,
    output logic                              es_gr_we,
    output logic [lsu_pkg::DATA_W-1:0]        es_result,
    output logic [lsu_pkg::DATA_W-1:0]        es_vaddr,
    output logic                              es_mem_req,
    output excp_pkg::ecode_e                  es_ecode,
    output logic                              es_ertn,
    output logic [lsu_pkg::DATA_W-1:0]        es_pc,
    output logic                              sram_req,
    output logic                              sram_wr,
    output logic [$clog2(SRAM_DEPTH)-1:0]     sram_addr,
    output logic [lsu_pkg::DATA_W-1:0]        sram_wdata
);
    import lsu_pkg::*;
    import excp_pkg::*;

    localparam int AW = $clog2(SRAM_DEPTH);

    logic              es_valid;
    logic              es_ready_go;
    op_e               op_r;
    logic [REG_AW-1:0] rj_r, rk_r, rd_r;
    logic [DATA_W-1:0] imm_r, pc_r;
    logic              use_rj, use_rk, mem_op, misaligned;
    logic [DATA_W-1:0] rj_val, rk_val, addr;

    // ******************************
    // operand read with forwarding
    // ******************************
    assign rf_raddr1 = rj_r;
    assign rf_raddr2 = rk_r;

    assign rj_val = (ms_fwd_valid && ms_fwd_dest == rj_r) ? ms_fwd_data :
                    (ws_fwd_valid && ws_fwd_dest == rj_r) ? ws_fwd_data : rf_rdata1;
    assign rk_val = (ms_fwd_valid && ms_fwd_dest == rk_r) ? ms_fwd_data :
                    (ws_fwd_valid && ws_fwd_dest == rk_r) ? ws_fwd_data : rf_rdata2;

    assign mem_op = is_load(op_r) || is_store(op_r);
    assign use_rj = mem_op || op_r == op_add;
    assign use_rk = is_store(op_r);

    // a load still waiting in ms holds any consumer here.
    assign es_ready_go = !(ms_fwd_blk && ((use_rj && ms_fwd_dest == rj_r) ||
                                          (use_rk && ms_fwd_dest == rk_r)));

    assign in_allowin     = !flush && (!es_valid || es_ready_go && ms_allowin);
    assign es_to_ms_valid = es_valid && es_ready_go && !flush;

    // ******************************
    // address and exceptions
    // ******************************
    assign addr       = rj_val + imm_r;
    assign misaligned = (access_size(op_r) == 2'd1 && addr[0]) ||
                        (access_size(op_r) == 2'd2 && addr[1:0] != 2'b00);

    always_comb begin
        if (op_r == op_syscall) begin
            es_ecode = ecode_sys;
        end else if (mem_op && misaligned) begin
            es_ecode = ecode_ale;
        end else begin
            es_ecode = ecode_none;
        end
    end

    assign es_op      = op_r;
    assign es_dest    = rd_r;
    assign es_gr_we   = (op_r == op_add || is_load(op_r)) && rd_r != '0 && es_ecode == ecode_none;
    assign es_result  = addr;  // also the add result.
    assign es_vaddr   = addr;
    assign es_ertn    = op_r == op_ertn;
    assign es_pc      = pc_r;
    assign es_mem_req = mem_op && es_ecode == ecode_none && !ms_to_es_ex && !flush;

    assign sram_req   = es_to_ms_valid && ms_allowin && es_mem_req;
    assign sram_wr    = is_store(op_r);
    assign sram_addr  = addr[AW+1:2];
    assign sram_wdata = rk_val;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (flush) begin
            es_valid <= 1'b0;
        end else if (in_allowin) begin
            es_valid <= in_valid;
        end

        if (in_valid && in_allowin) begin
            op_r  <= in_op;
            rj_r  <= in_rj;
            rk_r  <= in_rk;
            rd_r  <= in_rd;
            imm_r <= in_imm;
            pc_r  <= in_pc;
        end
    end

    // a flush right after a request would leave its data_ok without an owner.
    a_no_req_on_flush: assert property (
        @(posedge clk) disable iff (reset) sram_req |-> !flush ##1 !flush
    ) else $error("memory request issued during or just before a flush.");

endmodule

// ==== verilog/excp_pkg.sv ====
package excp_pkg;

    localparam int ECODE_W = 6;
    localparam int BADV_W  = 32;

    // code values as in the loongarch estat.ecode field.
    typedef enum logic [ECODE_W-1:0] {
        ecode_none = 6'h00,
        ecode_ale  = 6'h09,
        ecode_sys  = 6'h0b
    } ecode_e;

endpackage

// ==== verilog/lsu_pkg.sv ====
package lsu_pkg;

    localparam int DATA_W = 32;
    localparam int REG_AW = 5;
    localparam int OP_W   = 4;  // nine ops do not fit in three bits.

    typedef enum logic [OP_W-1:0] {
        op_add,
        op_ld_b,
        op_ld_h,
        op_ld_w,
        op_ld_bu,
        op_ld_hu,
        op_st_w,
        op_syscall,
        op_ertn
    } op_e;

    function automatic logic is_load(op_e op);
        return op inside {op_ld_b, op_ld_h, op_ld_w, op_ld_bu, op_ld_hu};
    endfunction

    function automatic logic is_store(op_e op);
        return op == op_st_w;
    endfunction

    // log2 of the access size in bytes.
    function automatic logic [1:0] access_size(op_e op);
        case (op)
            op_ld_h, op_ld_hu: return 2'd1;
            op_ld_w, op_st_w:  return 2'd2;
            default:           return 2'd0;
        endcase
    endfunction

endpackage
